// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: commit_checker.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module commit_checker
    import commit_pkg::*;
(
    input  logic      clk,
    input  logic      chk_en_i,
    input  int        test_id_i,
    input  redirect_t exp_redirect_i,
    input  debug_wb_t exp_dbg_i [2],
    input  logic      exp_stall_i,
    input  word_t     exp_rf_i [2],
    input  word_t     exp_csr_i,
    input  word_t     csr_mask_i,
    input  redirect_t redirect_i,
    input  debug_wb_t dbg_i [2],
    input  logic      stall_i,
    input  word_t     rf_rdata_i [2],
    input  word_t     csr_rdata_i,
    output int        tests_o,
    output int        errors_o
);

    int n_tests = 0;
    int n_errors = 0;
    int mismatches = 0;

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            mismatches++;
        end
    endtask

    // Registered outputs still hold the previous cycle's result at this edge
    always @(posedge clk) begin
        if (chk_en_i) begin
            mismatches = 0;
            compare_word("redirect_o.valid", 32'(exp_redirect_i.valid), 32'(redirect_i.valid));
            if (exp_redirect_i.valid) begin
                compare_word("redirect_o.pc", exp_redirect_i.pc, redirect_i.pc);
            end
            compare_word("stall_o", 32'(exp_stall_i), 32'(stall_i));
            for (int i = 0; i < 2; i++) begin
                compare_word($sformatf("debug_o[%0d].wen", i), 32'(exp_dbg_i[i].wen),
                             32'(dbg_i[i].wen));
                // Trace contents only matter for a slot that wrote
                if (exp_dbg_i[i].wen) begin
                    compare_word($sformatf("debug_o[%0d].pc", i), exp_dbg_i[i].pc, dbg_i[i].pc);
                    compare_word($sformatf("debug_o[%0d].wnum", i), 32'(exp_dbg_i[i].wnum),
                                 32'(dbg_i[i].wnum));
                    compare_word($sformatf("debug_o[%0d].wdata", i), exp_dbg_i[i].wdata,
                                 dbg_i[i].wdata);
                end
                compare_word($sformatf("rf_rdata_o[%0d]", i), exp_rf_i[i], rf_rdata_i[i]);
            end
            // A zero mask marks a row without a CSR read
            if (csr_mask_i != '0) begin
                compare_word("csr_rdata_o", exp_csr_i & csr_mask_i, csr_rdata_i & csr_mask_i);
            end
            n_tests++;
            n_errors += mismatches;
            if (mismatches == 0) begin
                $display("test %0d: ok", test_id_i);
            end else begin
                $display("test %0d: %0d mismatches", test_id_i, mismatches);
            end
        end
    end

    assign tests_o  = n_tests;
    assign errors_o = n_errors;

endmodule

// File: commit_pkg.sv
`include "cpu_macros.svh"

package commit_pkg;

    import csr_pkg::*;

    typedef logic [`GRLEN-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;

    // One retiring instruction as seen by the commit stage
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
        logic      csr_we;
        csr_addr_t csr_addr;
        word_t     csr_wdata;
        logic      excp;
        ecode_t    ecode;
        logic      ertn;
        logic      idle;
        logic      branch;
        word_t     branch_target;
    } commit_slot_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } reg_wr_t;

    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } debug_wb_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
    } redirect_t;

endpackage

// File: commit_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module commit_top
    import commit_pkg::*;
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  commit_slot_t        commit_i [`ISSUE_WIDTH],
    input  logic [`NUM_HWI-1:0] intrpt_i,
    input  reg_addr_t           rf_raddr_i [2],
    output word_t               rf_rdata_o [2],
    input  csr_addr_t           csr_raddr_i,
    output word_t               csr_rdata_o,
    output redirect_t           redirect_o,
    output logic                stall_o,
    output debug_wb_t           debug_o [`ISSUE_WIDTH]
);

    logic [`ISSUE_WIDTH-1:0] retire;
    csr_wr_t                 csr_wr;
    trap_evt_t               trap;
    logic                    irq_pending;
    word_t                   eentry, era;
    word_t                   tcfg, tval;
    logic                    timer_irq;
    reg_wr_t                 rf_wr [`ISSUE_WIDTH];

    // Debug trace, one registered entry per slot
    logic [`ISSUE_WIDTH-1:0] dbg_wen_q;
    word_t                   dbg_pc_q    [`ISSUE_WIDTH];
    reg_addr_t               dbg_wnum_q  [`ISSUE_WIDTH];
    word_t                   dbg_wdata_q [`ISSUE_WIDTH];

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        // Excepting slots and r0 targets produce no write
        assign rf_wr[i] = '{
            we:    retire[i] && commit_i[i].rf_we && !commit_i[i].excp &&
                   (commit_i[i].rf_waddr != '0),
            waddr: commit_i[i].rf_waddr,
            wdata: commit_i[i].rf_wdata
        };

        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                dbg_wen_q[i] <= 1'b0;
            end else begin
                dbg_wen_q[i] <= rf_wr[i].we;
            end
        end

        always_ff @(posedge clk) begin
            dbg_pc_q[i]    <= commit_i[i].pc;
            dbg_wnum_q[i]  <= rf_wr[i].waddr;
            dbg_wdata_q[i] <= rf_wr[i].wdata;
        end

        assign debug_o[i] = '{
            pc:    dbg_pc_q[i],
            wen:   dbg_wen_q[i],
            wnum:  dbg_wnum_q[i],
            wdata: dbg_wdata_q[i]
        };
    end

    trap_ctrl u_trap_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .commit_i      (commit_i),
        .irq_pending_i (irq_pending),
        .eentry_i      (eentry),
        .era_i         (era),
        .retire_o      (retire),
        .csr_wr_o      (csr_wr),
        .trap_o        (trap),
        .redirect_o    (redirect_o),
        .stall_o       (stall_o)
    );

    timer_unit u_timer_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .csr_wr_i    (csr_wr),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .timer_irq_o (timer_irq)
    );

    csr_file u_csr_file (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_wr_i      (csr_wr),
        .trap_i        (trap),
        .intrpt_i      (intrpt_i),
        .timer_irq_i   (timer_irq),
        .tcfg_i        (tcfg),
        .tval_i        (tval),
        .csr_raddr_i   (csr_raddr_i),
        .csr_rdata_o   (csr_rdata_o),
        .irq_pending_o (irq_pending),
        .eentry_o      (eentry),
        .era_o         (era)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (rf_wr),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Commit slots retired per cycle, slot 0 is the older one
`define ISSUE_WIDTH 2

// Data and address width
`define GRLEN 32

// Architectural general registers
`define NUM_GPR 32

// External hardware interrupt lines
`define NUM_HWI 8

// CSR address space width
`define CSR_ADDR_W 14

`endif

// File: csr_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module csr_file
    import commit_pkg::*;
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  csr_wr_t            csr_wr_i,
    input  trap_evt_t          trap_i,
    input  logic [`NUM_HWI-1:0] intrpt_i,
    input  logic               timer_irq_i,
    input  word_t              tcfg_i,
    input  word_t              tval_i,
    input  csr_addr_t          csr_raddr_i,
    output word_t              csr_rdata_o,
    output logic               irq_pending_o,
    output word_t              eentry_o,
    output word_t              era_o
);

    // CRMD and PRMD hold {ie, plv}
    logic [2:0]          crmd_q;
    logic [2:0]          prmd_q;
    logic [11:0]         ecfg_lie_q;
    logic [1:0]          estat_sw_q;
    logic [`NUM_HWI-1:0] estat_hw_q;
    logic                estat_ti_q;
    ecode_t              estat_ecode_q;
    word_t               era_q;
    logic [25:0]         eentry_q;
    word_t               estat_w;
    logic                ticlr_wr;

    assign estat_w = {10'b0, estat_ecode_q, 4'b0, estat_ti_q, 1'b0, estat_hw_q, estat_sw_q};

    assign ticlr_wr = csr_wr_i.we && (csr_wr_i.addr == CSR_TICLR) && csr_wr_i.wdata[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_q        <= '0;
            prmd_q        <= '0;
            ecfg_lie_q    <= '0;
            estat_sw_q    <= '0;
            estat_hw_q    <= '0;
            estat_ti_q    <= 1'b0;
            estat_ecode_q <= '0;
            era_q         <= '0;
            eentry_q      <= '0;
        end else begin
            if (trap_i.excp) begin
                // Save privilege and mask interrupts on entry
                prmd_q        <= crmd_q;
                crmd_q        <= 3'b000;
                estat_ecode_q <= trap_i.ecode;
                era_q         <= trap_i.era;
            end else if (trap_i.ertn) begin
                crmd_q <= prmd_q;
            end else if (csr_wr_i.we) begin
                case (csr_wr_i.addr)
                    CSR_CRMD:   crmd_q     <= csr_wr_i.wdata[2:0];
                    CSR_PRMD:   prmd_q     <= csr_wr_i.wdata[2:0];
                    CSR_ECFG:   ecfg_lie_q <= csr_wr_i.wdata[11:0];
                    CSR_ESTAT:  estat_sw_q <= csr_wr_i.wdata[1:0];
                    CSR_ERA:    era_q      <= csr_wr_i.wdata;
                    CSR_EENTRY: eentry_q   <= csr_wr_i.wdata[`GRLEN-1:6];
                    default:    ;
                endcase
            end

            // Hardware lines are sampled every cycle
            estat_hw_q <= intrpt_i;

            // A fresh timer tick wins over a clear on the same edge
            if (timer_irq_i) begin
                estat_ti_q <= 1'b1;
            end else if (ticlr_wr) begin
                estat_ti_q <= 1'b0;
            end
        end
    end

    assign irq_pending_o = crmd_q[2] && (|(estat_w[11:0] & ecfg_lie_q));
    assign eentry_o      = {eentry_q, 6'b0};
    assign era_o         = era_q;

    always_comb begin
        case (csr_raddr_i)
            CSR_CRMD:   csr_rdata_o = word_t'(crmd_q);
            CSR_PRMD:   csr_rdata_o = word_t'(prmd_q);
            CSR_ECFG:   csr_rdata_o = word_t'(ecfg_lie_q);
            CSR_ESTAT:  csr_rdata_o = estat_w;
            CSR_ERA:    csr_rdata_o = era_q;
            CSR_EENTRY: csr_rdata_o = eentry_o;
            CSR_TCFG:   csr_rdata_o = tcfg_i;
            CSR_TVAL:   csr_rdata_o = tval_i;
            default:    csr_rdata_o = '0;
        endcase
    end

    // Slot 0 carries one privileged operation at a time
    a_trap_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(trap_i.excp && trap_i.ertn))
        else $error("exception entry and ertn in the same cycle");

endmodule

// File: csr_pkg.sv
`include "cpu_macros.svh"

package csr_pkg;

    // Raw CSR number as carried by a commit slot
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // Exception code as stored in ESTAT 21:16
    typedef logic [5:0] ecode_t;

    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_SYS = 6'h0b;

    typedef struct packed {
        logic                  we;
        csr_addr_t             addr;
        logic [`GRLEN-1:0]     wdata;
    } csr_wr_t;

    // Exception entry or return, applied by the CSR file
    typedef struct packed {
        logic                  excp;
        logic                  ertn;
        ecode_t                ecode;
        logic [`GRLEN-1:0]     era;
    } trap_evt_t;

    typedef enum logic {
        RUN,
        IDLE_WAIT
    } trap_state_e;

endpackage

// File: regfile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regfile
    import commit_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_wr_t   wr_i [`ISSUE_WIDTH],
    input  reg_addr_t raddr_i [2],
    output word_t     rdata_o [2]
);

    word_t regs [`NUM_GPR];

    // Later port is the younger slot, so it overrides on a shared register
    always_ff @(posedge clk) begin
        if (rst_n_i) begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (wr_i[i].we && (wr_i[i].waddr != '0)) begin
                    regs[wr_i[i].waddr] <= wr_i[i].wdata;
                end
            end
        end
    end

    // r0 is hardwired to zero
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (raddr_i[i] == '0) begin
                rdata_o[i] = '0;
            end else begin
                rdata_o[i] = regs[raddr_i[i]];
            end
        end
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_top
    import commit_pkg::*;
    import csr_pkg::*;
();

    localparam int    NUM_ROWS    = 18;
    localparam int    TIMER_INIT  = 16;
    localparam int    CYCLE_LIMIT = 2 * NUM_ROWS + TIMER_INIT + 50;
    localparam word_t PC_BASE     = 32'h1c00_0000;
    localparam word_t EENTRY_VAL  = 32'h1c00_80c0;
    localparam word_t BR_T0       = 32'h1c00_4000;
    localparam word_t BR_T1       = 32'h1c00_5000;

    // One cycle of stimulus with the results expected one cycle later
    typedef struct packed {
        logic                check;
        commit_slot_t        s0;
        commit_slot_t        s1;
        logic [`NUM_HWI-1:0] intr;
        redirect_t           exp_rd;
        logic [1:0]          exp_wen;
        logic                exp_stall;
        reg_addr_t           ra0;
        word_t               exp_r0;
        reg_addr_t           ra1;
        word_t               exp_r1;
        csr_addr_t           csr_a;
        word_t               csr_mask;
        word_t               exp_csr;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n;
    commit_slot_t        commit [`ISSUE_WIDTH];
    logic [`NUM_HWI-1:0] intrpt;
    reg_addr_t           rf_raddr [2];
    word_t               rf_rdata [2];
    csr_addr_t           csr_raddr;
    word_t               csr_rdata;
    redirect_t           redirect;
    logic                stall;
    debug_wb_t           debug [`ISSUE_WIDTH];

    // Expected values handed to the checker
    logic      chk_en;
    int        test_id;
    redirect_t exp_redirect;
    debug_wb_t exp_dbg [2];
    logic      exp_stall;
    word_t     exp_rf [2];
    word_t     exp_csr;
    word_t     csr_mask;
    int        n_tests;
    int        n_errors;

    row_t   rows [NUM_ROWS];
    row_t   prev_row;
    int     prev_id;
    integer seed;
    int     cycles = 0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    commit_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .commit_i    (commit),
        .intrpt_i    (intrpt),
        .rf_raddr_i  (rf_raddr),
        .rf_rdata_o  (rf_rdata),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .redirect_o  (redirect),
        .stall_o     (stall),
        .debug_o     (debug)
    );

    commit_checker u_checker (
        .clk            (clk),
        .chk_en_i       (chk_en),
        .test_id_i      (test_id),
        .exp_redirect_i (exp_redirect),
        .exp_dbg_i      (exp_dbg),
        .exp_stall_i    (exp_stall),
        .exp_rf_i       (exp_rf),
        .exp_csr_i      (exp_csr),
        .csr_mask_i     (csr_mask),
        .redirect_i     (redirect),
        .dbg_i          (debug),
        .stall_i        (stall),
        .rf_rdata_i     (rf_rdata),
        .csr_rdata_i    (csr_rdata),
        .tests_o        (n_tests),
        .errors_o       (n_errors)
    );

    function automatic word_t pc_of(input int r, input int s);
        return PC_BASE + word_t'(r * 8 + s * 4);
    endfunction

    function automatic commit_slot_t nop_slot(input word_t pc);
        commit_slot_t s;
        s = '0;
        s.valid = 1'b1;
        s.pc = pc;
        return s;
    endfunction

    function automatic commit_slot_t alu_slot(input word_t pc, input reg_addr_t rd,
                                              input word_t data);
        commit_slot_t s;
        s = nop_slot(pc);
        s.rf_we = 1'b1;
        s.rf_waddr = rd;
        s.rf_wdata = data;
        return s;
    endfunction

    function automatic commit_slot_t csr_write_slot(input word_t pc, input csr_addr_t a,
                                                    input word_t data);
        commit_slot_t s;
        s = nop_slot(pc);
        s.csr_we = 1'b1;
        s.csr_addr = a;
        s.csr_wdata = data;
        return s;
    endfunction

    task automatic rf_check(inout row_t r, input reg_addr_t a0, input word_t e0,
                            input reg_addr_t a1, input word_t e1);
        r.ra0 = a0;
        r.exp_r0 = e0;
        r.ra1 = a1;
        r.exp_r1 = e1;
    endtask

    task automatic csr_check(inout row_t r, input csr_addr_t a, input word_t mask,
                             input word_t val);
        r.csr_a = a;
        r.csr_mask = mask;
        r.exp_csr = val;
    endtask

    task automatic build_table();
        word_t d [9];
        for (int i = 0; i < 9; i++) begin
            d[i] = $random(seed);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r] = '0;
            rows[r].check = 1'b1;
        end
        rows[0].s0 = alu_slot(pc_of(0, 0), 5'd1, d[0]);
        rows[0].s1 = alu_slot(pc_of(0, 1), 5'd2, d[1]);
        rows[0].exp_wen = 2'b11;
        rf_check(rows[0], 5'd1, d[0], 5'd2, d[1]);
        // Same register from both slots
        rows[1].s0 = alu_slot(pc_of(1, 0), 5'd3, d[2]);
        rows[1].s1 = alu_slot(pc_of(1, 1), 5'd3, d[3]);
        rows[1].exp_wen = 2'b11;
        rf_check(rows[1], 5'd3, d[3], 5'd0, 32'h0);
        rows[2].s0 = alu_slot(pc_of(2, 0), 5'd0, d[4]);
        rows[2].s1 = alu_slot(pc_of(2, 1), 5'd4, d[5]);
        rows[2].exp_wen = 2'b10;
        rf_check(rows[2], 5'd0, 32'h0, 5'd4, d[5]);
        // Slot 0 branch keeps the slot 1 write from landing
        rows[3].s0 = nop_slot(pc_of(3, 0));
        rows[3].s0.branch = 1'b1;
        rows[3].s0.branch_target = BR_T0;
        rows[3].s1 = alu_slot(pc_of(3, 1), 5'd4, d[6]);
        rows[3].exp_rd = {1'b1, BR_T0};
        rf_check(rows[3], 5'd4, d[5], 5'd3, d[3]);
        rows[4].s0 = csr_write_slot(pc_of(4, 0), CSR_EENTRY, 32'h1c00_80ff);
        csr_check(rows[4], CSR_EENTRY, 32'hffff_ffff, EENTRY_VAL);
        rows[5].s0 = alu_slot(pc_of(5, 0), 5'd6, d[7]);
        rows[5].s1 = nop_slot(pc_of(5, 1));
        rows[5].s1.branch = 1'b1;
        rows[5].s1.branch_target = BR_T1;
        rows[5].exp_rd = {1'b1, BR_T1};
        rows[5].exp_wen = 2'b01;
        rf_check(rows[5], 5'd6, d[7], 5'd0, 32'h0);
        rows[6].s0 = csr_write_slot(pc_of(6, 0), CSR_ERA, 32'h1234_5678);
        csr_check(rows[6], CSR_ERA, 32'hffff_ffff, 32'h1234_5678);
        // Lines 2 and 11 enabled and upper bits dropped
        rows[7].s0 = csr_write_slot(pc_of(7, 0), CSR_ECFG, 32'hffff_f804);
        csr_check(rows[7], CSR_ECFG, 32'hffff_ffff, 32'h0000_0804);
        rows[8].s0 = csr_write_slot(pc_of(8, 0), CSR_CRMD, 32'hffff_ff07);
        csr_check(rows[8], CSR_CRMD, 32'hffff_ffff, 32'h0000_0007);
        // Syscall from slot 0 with plv 3 and ie set
        rows[9].s0 = nop_slot(pc_of(9, 0));
        rows[9].s0.excp = 1'b1;
        rows[9].s0.ecode = ECODE_SYS;
        rows[9].s1 = alu_slot(pc_of(9, 1), 5'd7, d[8]);
        rows[9].exp_rd = {1'b1, EENTRY_VAL};
        csr_check(rows[9], CSR_ERA, 32'hffff_ffff, pc_of(9, 0));
        rows[10].s0 = nop_slot(pc_of(10, 0));
        csr_check(rows[10], CSR_ESTAT, 32'h003f_0000, 32'h000b_0000);
        rows[11].s0 = nop_slot(pc_of(11, 0));
        csr_check(rows[11], CSR_CRMD, 32'h0000_0007, 32'h0);
        rows[12].s0 = nop_slot(pc_of(12, 0));
        csr_check(rows[12], CSR_PRMD, 32'h0000_0007, 32'h0000_0007);
        rows[13].s0 = nop_slot(pc_of(13, 0));
        rows[13].s0.ertn = 1'b1;
        rows[13].exp_rd = {1'b1, pc_of(9, 0)};
        csr_check(rows[13], CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
        // Idle until hardware line 0 wakes it
        rows[14].s0 = nop_slot(pc_of(14, 0));
        rows[14].s0.idle = 1'b1;
        rows[14].exp_stall = 1'b1;
        rows[15].intr = 8'h01;
        rows[15].exp_stall = 1'b1;
        rows[16].exp_rd = {1'b1, EENTRY_VAL};
        csr_check(rows[16], CSR_ERA, 32'hffff_ffff, pc_of(14, 0) + 32'd4);
        rows[17].s0 = csr_write_slot(pc_of(17, 0), CSR_CRMD, 32'h0000_0004);
        csr_check(rows[17], CSR_CRMD, 32'h0000_0007, 32'h0000_0004);
    endtask

    task automatic drive_row(input row_t r);
        commit[0] = r.s0;
        commit[1] = r.s1;
        intrpt = r.intr;
    endtask

    task automatic expect_row(input row_t r, input int id);
        commit_slot_t s;
        chk_en = r.check;
        test_id = id;
        exp_redirect = r.exp_rd;
        exp_stall = r.exp_stall;
        for (int i = 0; i < 2; i++) begin
            s = (i == 0) ? r.s0 : r.s1;
            exp_dbg[i] = '{pc: s.pc, wen: r.exp_wen[i], wnum: s.rf_waddr, wdata: s.rf_wdata};
        end
        rf_raddr[0] = r.ra0;
        rf_raddr[1] = r.ra1;
        exp_rf[0] = r.exp_r0;
        exp_rf[1] = r.exp_r1;
        csr_raddr = r.csr_a;
        csr_mask = r.csr_mask;
        exp_csr = r.exp_csr;
    endtask

    // Check the previous row and present the next one
    task automatic step(input row_t nxt, input int nxt_id);
        @(negedge clk);
        expect_row(prev_row, prev_id);
        drive_row(nxt);
        prev_row = nxt;
        prev_id = nxt_id;
    endtask

    initial begin
        row_t tcfg_row;
        row_t wait_row;
        row_t irq_row;
        row_t ticlr_row;
        logic seen;
        seed = 32'hda6d556d;
        rst_n = 1'b0;
        commit[0] = '0;
        commit[1] = '0;
        intrpt = '0;
        rf_raddr[0] = '0;
        rf_raddr[1] = '0;
        csr_raddr = '0;
        prev_row = '0;
        prev_id = 0;
        expect_row(prev_row, 0);
        build_table();

        tcfg_row = '0;
        tcfg_row.check = 1'b1;
        tcfg_row.s0 = csr_write_slot(pc_of(NUM_ROWS, 0), CSR_TCFG,
                                     word_t'(TIMER_INIT) | 32'h1);
        csr_check(tcfg_row, CSR_TCFG, 32'hffff_ffff, word_t'(TIMER_INIT) | 32'h1);
        wait_row = '0;
        wait_row.s0 = nop_slot(pc_of(NUM_ROWS + 1, 0));
        irq_row = '0;
        irq_row.check = 1'b1;
        irq_row.exp_rd = {1'b1, EENTRY_VAL};
        csr_check(irq_row, CSR_ESTAT, 32'h003f_0800, 32'h0000_0800);
        ticlr_row = '0;
        ticlr_row.check = 1'b1;
        ticlr_row.s0 = csr_write_slot(pc_of(NUM_ROWS + 2, 0), CSR_TICLR, 32'h1);
        csr_check(ticlr_row, CSR_ESTAT, 32'h0000_0800, 32'h0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            step(rows[r], r);
        end
        step(tcfg_row, NUM_ROWS);
        step(wait_row, 0);

        // Keep slot 0 busy until the timer interrupt redirects
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (redirect.valid) begin
                seen = 1'b1;
            end else begin
                chk_en = 1'b0;
                drive_row(wait_row);
            end
        end
        expect_row(irq_row, NUM_ROWS + 1);
        drive_row(ticlr_row);
        prev_row = ticlr_row;
        prev_id = NUM_ROWS + 2;
        step(wait_row, 0);
        @(negedge clk);
        chk_en = 1'b0;

        $display("tests %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: timer_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module timer_unit
    import commit_pkg::*;
    import csr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  csr_wr_t csr_wr_i,
    output word_t   tcfg_o,
    output word_t   tval_o,
    output logic    timer_irq_o
);

    word_t tcfg_q;
    word_t tval_q;
    logic  irq_q;
    logic  tcfg_wr;
    logic  tcfg_en, tcfg_periodic;

    assign tcfg_wr       = csr_wr_i.we && (csr_wr_i.addr == CSR_TCFG);
    assign tcfg_en       = tcfg_q[0];
    assign tcfg_periodic = tcfg_q[1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tcfg_q <= '0;
            tval_q <= '0;
            irq_q  <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (tcfg_wr) begin
                tcfg_q <= csr_wr_i.wdata;
                // Enable loads the full initval, low two bits zero
                if (csr_wr_i.wdata[0]) begin
                    tval_q <= {csr_wr_i.wdata[`GRLEN-1:2], 2'b00};
                end
            end else if (tcfg_en) begin
                if (tval_q != '0) begin
                    tval_q <= tval_q - 1'b1;
                    irq_q  <= (tval_q == word_t'(1));
                end else if (tcfg_periodic) begin
                    tval_q <= {tcfg_q[`GRLEN-1:2], 2'b00};
                end
            end
        end
    end

    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    // One-cycle pulse as the count hits zero
    assign timer_irq_o = irq_q;

    a_tval_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!tcfg_en && !tcfg_wr) |=> $stable(tval_q))
        else $error("TVAL moved while the timer was disabled");

endmodule

// File: trap_ctrl.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module trap_ctrl
    import commit_pkg::*;
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  commit_slot_t            commit_i [`ISSUE_WIDTH],
    input  logic                    irq_pending_i,
    input  word_t                   eentry_i,
    input  word_t                   era_i,
    output logic [`ISSUE_WIDTH-1:0] retire_o,
    output csr_wr_t                 csr_wr_o,
    output trap_evt_t               trap_o,
    output redirect_t               redirect_o,
    output logic                    stall_o
);

    trap_state_e  state_q, state_d;
    word_t        idle_pc_q;
    commit_slot_t s0, s1;
    logic         run, int_run, idle_wake, s0_exec;
    logic         take_excp, take_ertn, enter_idle, br0, br1;
    redirect_t    redirect_d;
    logic         redirect_valid_q;
    word_t        redirect_pc_q;

    assign s0  = commit_i[0];
    assign s1  = commit_i[1];
    assign run = (state_q == RUN);

    // An interrupt preempts slot 0, nothing retires on that cycle
    assign int_run   = run && s0.valid && irq_pending_i;
    assign idle_wake = (state_q == IDLE_WAIT) && irq_pending_i;

    assign retire_o[0] = run && s0.valid && !irq_pending_i;
    assign retire_o[1] = retire_o[0] && s1.valid &&
                         !(s0.excp || s0.ertn || s0.idle || s0.branch);

    // Slot 0 retires and actually executes
    assign s0_exec    = retire_o[0] && !s0.excp;
    assign take_excp  = int_run || (retire_o[0] && s0.excp);
    assign take_ertn  = s0_exec && s0.ertn;
    assign enter_idle = s0_exec && s0.idle;
    assign br0        = s0_exec && s0.branch;
    assign br1        = retire_o[1] && s1.branch;

    assign csr_wr_o = '{we: s0_exec && s0.csr_we, addr: s0.csr_addr, wdata: s0.csr_wdata};

    // Wake from idle resumes after the idle instruction
    assign trap_o = '{
        excp:  take_excp || idle_wake,
        ertn:  take_ertn,
        ecode: (int_run || idle_wake) ? ECODE_INT : s0.ecode,
        era:   idle_wake ? idle_pc_q + 32'd4 : s0.pc
    };

    always_comb begin
        redirect_d = '0;
        if (take_excp) begin
            redirect_d = '{valid: 1'b1, pc: eentry_i};
        end else if (take_ertn) begin
            redirect_d = '{valid: 1'b1, pc: era_i};
        end else if (idle_wake) begin
            redirect_d = '{valid: 1'b1, pc: eentry_i};
        end else if (br0) begin
            redirect_d = '{valid: 1'b1, pc: s0.branch_target};
        end else if (br1) begin
            redirect_d = '{valid: 1'b1, pc: s1.branch_target};
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN:       if (enter_idle) state_d = IDLE_WAIT;
            IDLE_WAIT: if (irq_pending_i) state_d = RUN;
            default:   state_d = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q          <= RUN;
            redirect_valid_q <= 1'b0;
        end else begin
            state_q          <= state_d;
            redirect_valid_q <= redirect_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc_q <= redirect_d.pc;
        if (enter_idle) begin
            idle_pc_q <= s0.pc;
        end
    end

    assign redirect_o = '{valid: redirect_valid_q, pc: redirect_pc_q};
    assign stall_o    = (state_q == IDLE_WAIT);

    // Privileged operations issue alone, so they only ever reach slot 0
    a_slot1_plain: assert property (@(posedge clk) disable iff (!rst_n_i)
        s1.valid |-> !(s1.csr_we || s1.excp || s1.ertn || s1.idle))
        else $error("privileged operation in commit slot 1");

    // A redirect flushes the younger commits, so it never repeats back to back
    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o.valid |=> !redirect_o.valid)
        else $error("redirect held for two cycles");

endmodule

// File: vlog.f
+incdir+.
csr_pkg.sv
commit_pkg.sv
trap_ctrl.sv
timer_unit.sv
csr_file.sv
regfile.sv
commit_top.sv
commit_checker.sv
tb_top.sv
